/* project.f */
hw/lsu_pkg.sv
hw/lsu_decode.sv
hw/lsu_mem_if.sv
hw/lsu_result.sv
hw/lsu_top.sv
test/lsu_bus_mem.sv
test/lsu_checker.sv
test/tb_lsu.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the LSU testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f project.f --top-module tb_lsu -o sim_lsu
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/sim_lsu > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Simulation finished: PASS" "$LOG"; then
   exit 0
fi
echo "Pass message not found in $LOG"
exit 1

/* test/tb_lsu.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_lsu
   import lsu_pkg::*;
;

   typedef struct packed {
      logic [127:0] name;
      logic [2:0]   f3;
      logic         st;
      logic [3:0]   waddr;
      logic [1:0]   lsb;
      logic [31:0]  data;
      logic [3:0]   sel;
      logic [31:0]  exp;
      logic         mis;
   } row_t;

   logic clk = 1'b0;
   logic rst, start, store, rs2, ack, done, init, busy, misalign, rd_valid, we, cyc;
   logic [2:0]      funct3;
   logic [1:0]      lsb;
   logic [XLEN-1:0] rdt, rd_data, bus_dat, peek;
   logic [3:0]      sel;
   logic [127:0]    cur_name;
   logic [3:0]      cur_sel, cur_waddr;
   logic [31:0]     cur_exp;
   logic            cur_mis, cur_store;
   int              errors;
   row_t            rows [$];

   always #4 clk = ~clk;

   lsu_top dut_i (
      .i_clk(clk), .i_rst(rst), .i_start(start), .i_funct3(funct3), .i_store(store),
      .i_lsb(lsb), .i_rs2(rs2), .i_bus_rdt(rdt), .i_bus_ack(ack),
      .o_init(init), .o_busy(busy), .o_done(done), .o_misalign(misalign),
      .o_rd_data(rd_data), .o_rd_valid(rd_valid), .o_bus_dat(bus_dat),
      .o_bus_sel(sel), .o_bus_we(we), .o_bus_cyc(cyc)
   );

   lsu_bus_mem mem_i (
      .i_clk(clk), .i_rst(rst), .i_word_addr(cur_waddr), .i_cyc(cyc), .i_we(we),
      .i_sel(sel), .i_dat(bus_dat), .o_rdt(rdt), .o_ack(ack), .o_peek(peek)
   );

   lsu_checker chk_i (
      .i_clk(clk), .i_rst(rst), .i_busy(busy), .i_init(init), .i_done(done),
      .i_misalign(misalign), .i_rd_data(rd_data), .i_rd_valid(rd_valid), .i_cyc(cyc),
      .i_we(we), .i_sel(sel), .i_ack(ack), .i_name(cur_name), .i_exp_sel(cur_sel),
      .i_exp_word(cur_exp), .i_exp_mis(cur_mis), .i_is_store(cur_store),
      .i_mem_word(peek), .o_errors(errors)
   );

   task automatic add_row(input logic [127:0] name, input logic [2:0] f3, input logic st,
                          input logic [3:0] waddr, input logic [1:0] a, input logic [31:0] data,
                          input logic [3:0] s, input logic [31:0] exp, input logic mis);
      rows.push_back('{name, f3, st, waddr, a, data, s, exp, mis});
   endtask

   // Memory bytes are {addr, lane, 01}, so word 9 reads 9d999591
   task automatic build_table();
      add_row("lw_aligned",  3'd2, 0, 4'd9,  2'd0, 32'h0,        4'hf, 32'h9d999591, 0);
      add_row("sw_aligned",  3'd2, 1, 4'd2,  2'd0, 32'hcafef00d, 4'hf, 32'hcafef00d, 0);
      add_row("lb_off0",     3'd0, 0, 4'd9,  2'd0, 32'h0,        4'h1, 32'hffffff91, 0);
      add_row("lb_off1",     3'd0, 0, 4'd9,  2'd1, 32'h0,        4'h2, 32'hffffff95, 0);
      add_row("lb_off2",     3'd0, 0, 4'd9,  2'd2, 32'h0,        4'h4, 32'hffffff99, 0);
      add_row("lb_off3",     3'd0, 0, 4'd9,  2'd3, 32'h0,        4'h8, 32'hffffff9d, 0);
      add_row("lbu_off0",    3'd4, 0, 4'd9,  2'd0, 32'h0,        4'h1, 32'h00000091, 0);
      add_row("lbu_off3",    3'd4, 0, 4'd9,  2'd3, 32'h0,        4'h8, 32'h0000009d, 0);
      add_row("lb_pos",      3'd0, 0, 4'd3,  2'd2, 32'h0,        4'h4, 32'h00000039, 0);
      add_row("sb_off0",     3'd0, 1, 4'd4,  2'd0, 32'h123456ab, 4'h1, 32'h4d4945ab, 0);
      add_row("sb_off1",     3'd0, 1, 4'd5,  2'd1, 32'h000000c3, 4'h2, 32'h5d59c351, 0);
      add_row("sb_off2",     3'd0, 1, 4'd6,  2'd2, 32'hffffff7e, 4'h4, 32'h6d7e6561, 0);
      add_row("sb_off3",     3'd0, 1, 4'd7,  2'd3, 32'h00000011, 4'h8, 32'h11797571, 0);
      add_row("lh_off0",     3'd1, 0, 4'd9,  2'd0, 32'h0,        4'h3, 32'hffff9591, 0);
      add_row("lh_off2",     3'd1, 0, 4'd9,  2'd2, 32'h0,        4'hc, 32'hffff9d99, 0);
      add_row("lhu_off2",    3'd5, 0, 4'd10, 2'd2, 32'h0,        4'hc, 32'h0000ada9, 0);
      add_row("lh_pos",      3'd1, 0, 4'd3,  2'd0, 32'h0,        4'h3, 32'h00003531, 0);
      add_row("sh_off0",     3'd1, 1, 4'd11, 2'd0, 32'hdeadbeef, 4'h3, 32'hbdb9beef, 0);
      add_row("sh_off2",     3'd1, 1, 4'd12, 2'd2, 32'h00001234, 4'hc, 32'h1234c5c1, 0);
      add_row("lh_mis1",     3'd1, 0, 4'd13, 2'd1, 32'h0,        4'h0, 32'hddd9d5d1, 1);
      add_row("sh_mis3",     3'd1, 1, 4'd14, 2'd3, 32'h0000ffff, 4'h0, 32'hede9e5e1, 1);
      add_row("lw_mis2",     3'd2, 0, 4'd13, 2'd2, 32'h0,        4'h0, 32'hddd9d5d1, 1);
      add_row("sw_mis1",     3'd2, 1, 4'd14, 2'd1, 32'h0,        4'h0, 32'hede9e5e1, 1);
      add_row("lw_after_sw", 3'd2, 0, 4'd2,  2'd0, 32'h0,        4'hf, 32'hcafef00d, 0);
   endtask

   task automatic run_access(input row_t r);
      cur_name  = r.name;
      cur_sel   = r.sel;
      cur_waddr = r.waddr;
      cur_exp   = r.exp;
      cur_mis   = r.mis;
      cur_store = r.st;
      start  = 1'b1;
      funct3 = r.f3;
      store  = r.st;
      lsb    = r.lsb;
      @(posedge clk);
      #1 start = 1'b0;
      for (int k = 0; k < 32; k++) begin   // One store bit per init cycle
         rs2 = r.data[k];
         @(posedge clk);
         #1;
      end
      rs2    = 1'b0;
      start  = 1'b1;   // Stray strobe while busy
      funct3 = ~r.f3;
      store  = ~r.st;
      lsb    = ~r.lsb;
      @(posedge clk);
      #1 start = 1'b0;
      while (!done) begin
         @(posedge clk);
         #1;
      end
      @(posedge clk);
      #1;
   endtask

   initial begin
      rst       = 1'b1;
      start     = 1'b0;
      funct3    = 3'd0;
      store     = 1'b0;
      lsb       = 2'd0;
      rs2       = 1'b0;
      cur_name  = "reset";
      cur_sel   = 4'h0;
      cur_waddr = 4'd0;
      cur_exp   = 32'h0;
      cur_mis   = 1'b0;
      cur_store = 1'b0;
      build_table();
      repeat (16) @(posedge clk);
      #1 rst = 1'b0;
      @(posedge clk);
      #1;
      foreach (rows[i])
         run_access(rows[i]);
      repeat (4) @(posedge clk);
      chk_i.print_summary();
      if (errors == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

   // Per access about 80 cycles plus up to 4 ack wait cycles
   initial begin
      time limit;
      #1;
      limit = (rows.size() * (80 + 4) + 16 + 8) * 8;
      #(limit);
      $display("Timeout: the accesses did not finish within %0t ns", limit);
      $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

/* test/lsu_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module lsu_checker
   import lsu_pkg::*;
(
   input  logic            i_clk,
   input  logic            i_rst,
   input  logic            i_busy,
   input  logic            i_init,
   input  logic            i_done,
   input  logic            i_misalign,
   input  logic [XLEN-1:0] i_rd_data,
   input  logic            i_rd_valid,
   input  logic            i_cyc,
   input  logic            i_we,
   input  logic [3:0]      i_sel,
   input  logic            i_ack,
   input  logic [127:0]    i_name,
   input  logic [3:0]      i_exp_sel,
   input  logic [XLEN-1:0] i_exp_word,
   input  logic            i_exp_mis,
   input  logic            i_is_store,
   input  logic [XLEN-1:0] i_mem_word,
   output int              o_errors
);

   int   checks = 0;
   int   errors = 0;
   int   init_cycles = 0;
   logic ack_q  = 1'b0;
   logic rst_q  = 1'b0;
   logic cyc_prev = 1'b0;
   logic saw_cyc = 1'b0;

   assign o_errors = errors;

   function automatic string name_str(input logic [127:0] v);
      string s;
      s = "";
      for (int i = 15; i >= 0; i--)
         if (v[i*8 +: 8] != 8'h00)
            s = $sformatf("%s%c", s, v[i*8 +: 8]);
      return s;
   endfunction

   task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("ERROR %s %s: expected %h, actual %h", name_str(i_name), what, exp, act);
      end
   endtask

   task automatic fail_plain(input string msg);
      errors++;
      $display("Failure in %s: %s", name_str(i_name), msg);
   endtask

   always @(posedge i_clk) begin
      rst_q <= i_rst;
      if (i_rst) begin
         ack_q       <= 1'b0;
         cyc_prev    <= 1'b0;
         saw_cyc     <= 1'b0;
         init_cycles <= 0;
         if (rst_q && (i_cyc || i_busy || i_init || i_done || i_rd_valid))
            fail_plain("outputs not low during reset");
      end else begin
         ack_q    <= i_cyc && i_ack;
         cyc_prev <= i_cyc;
         if (i_init)
            init_cycles <= init_cycles + 1;
         else if (init_cycles != 0) begin   // Init phase just ended
            check_value("init cycles", 32'(XLEN), 32'(init_cycles));
            init_cycles <= 0;
         end
         if (i_cyc) begin
            saw_cyc <= 1'b1;
            if (i_exp_mis)
               fail_plain("bus cycle started for a misaligned access");
            else
               check_value("sel", {28'd0, i_exp_sel}, {28'd0, i_sel});
            check_value("we", {31'd0, i_is_store}, {31'd0, i_we});
         end
         if (cyc_prev && !i_cyc && !ack_q)
            fail_plain("cyc dropped before ack");
         if (ack_q && i_cyc)
            fail_plain("cyc still high the cycle after ack");
         if (ack_q && i_is_store && !i_done)
            fail_plain("store done did not follow ack by one cycle");
         if (i_rd_valid && !(i_done && !i_is_store && !i_exp_mis))
            fail_plain("result valid outside a load completion");
         if (i_done) begin   // End of one access
            check_value("misalign", {31'd0, i_exp_mis}, {31'd0, i_misalign});
            if (!i_exp_mis && !saw_cyc)
               fail_plain("access finished without a bus cycle");
            if (i_is_store || i_exp_mis)
               check_value("memory", i_exp_word, i_mem_word);
            else begin
               if (!i_rd_valid)
                  fail_plain("load finished without result valid");
               check_value("result", i_exp_word, i_rd_data);
            end
            saw_cyc <= 1'b0;
         end
      end
   end

   task automatic print_summary();
      $display("Checks: %0d, errors: %0d", checks, errors);
   endtask

endmodule

`default_nettype wire

/* test/lsu_bus_mem.sv */
`timescale 1ns/1ns
`default_nettype none

module lsu_bus_mem (
   input  logic        i_clk,
   input  logic        i_rst,
   input  logic [3:0]  i_word_addr,
   input  logic        i_cyc,
   input  logic        i_we,
   input  logic [3:0]  i_sel,
   input  logic [31:0] i_dat,
   output logic [31:0] o_rdt,
   output logic        o_ack,
   output logic [31:0] o_peek
);

   logic [31:0] mem [16];
   logic        pending;
   logic [1:0]  wait_cnt;
   integer      seed;

   // Byte k of word a is {a, k, 01}
   function automatic logic [31:0] fill_word(input logic [3:0] a);
      logic [31:0] w;
      for (int k = 0; k < 4; k++)
         w[k*8 +: 8] = {a, 2'(k), 2'b01};
      return w;
   endfunction

   initial begin
      seed = 32'h34fd983b;
      for (int a = 0; a < 16; a++)
         mem[a] = fill_word(4'(a));
   end

   always @(posedge i_clk) begin
      if (i_rst) begin
         o_ack    <= 1'b0;
         pending  <= 1'b0;
         wait_cnt <= 2'd0;
      end else if (o_ack) begin
         o_ack   <= 1'b0;
         pending <= 1'b0;
         if (i_cyc && i_we) begin
            for (int k = 0; k < 4; k++)
               if (i_sel[k])
                  mem[i_word_addr][k*8 +: 8] <= i_dat[k*8 +: 8];
         end
      end else if (i_cyc && !pending) begin
         pending  <= 1'b1;
         wait_cnt <= 2'($random(seed));   // 0 to 3 extra cycles
      end else if (pending) begin
         if (wait_cnt == 2'd0)
            o_ack <= 1'b1;
         else
            wait_cnt <= wait_cnt - 2'd1;
      end
   end

   assign o_rdt  = mem[i_word_addr];
   assign o_peek = mem[i_word_addr];

endmodule

`default_nettype wire

/* hw/lsu_top.sv */
`timescale 1ns/1ns
`default_nettype none

module lsu_top
   import lsu_pkg::*;
(
   input  logic                 i_clk,
   input  logic                 i_rst,
   input  logic                 i_start,
   input  logic [2:0]           i_funct3,
   input  logic                 i_store,
   input  logic [1:0]           i_lsb,
   input  logic                 i_rs2,
   input  logic [XLEN-1:0]      i_bus_rdt,
   input  logic                 i_bus_ack,
   output logic                 o_init,
   output logic                 o_busy,
   output logic                 o_done,
   output logic                 o_misalign,
   output logic [XLEN-1:0]      o_rd_data,
   output logic                 o_rd_valid,
   output logic [XLEN-1:0]      o_bus_dat,
   output logic [NUM_LANES-1:0] o_bus_sel,
   output logic                 o_bus_we,
   output logic                 o_bus_cyc
);

   mem_op_t     op;
   serial_ctl_t ctl;
   bus_req_t    req;
   logic        ack_evt;
   logic        rd;

   lsu_decode decode_i (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_start    (i_start),
      .i_funct3   (i_funct3),
      .i_store    (i_store),
      .i_lsb      (i_lsb),
      .i_misalign (o_misalign),
      .i_ack_evt  (ack_evt),
      .o_op       (op),
      .o_ctl      (ctl),
      .o_busy     (o_busy),
      .o_done     (o_done)
   );

   lsu_mem_if mem_if_i (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_op       (op),
      .i_ctl      (ctl),
      .i_rs2      (i_rs2),
      .i_bus_rdt  (i_bus_rdt),
      .i_bus_ack  (i_bus_ack),
      .o_req      (req),
      .o_misalign (o_misalign),
      .o_ack_evt  (ack_evt),
      .o_rd       (rd)
   );

   lsu_result result_i (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_ctl      (ctl),
      .i_rd       (rd),
      .o_rd_data  (o_rd_data),
      .o_rd_valid (o_rd_valid)
   );

   assign o_init    = ctl.init;
   assign o_bus_dat = req.dat;
   assign o_bus_sel = req.sel;
   assign o_bus_we  = req.we;
   assign o_bus_cyc = req.cyc;

endmodule

`default_nettype wire

/* hw/lsu_result.sv */
`timescale 1ns/1ns
`default_nettype none

module lsu_result
   import lsu_pkg::*;
(
   input  logic            i_clk,
   input  logic            i_rst,
   input  serial_ctl_t     i_ctl,
   input  logic            i_rd,
   output logic [XLEN-1:0] o_rd_data,
   output logic            o_rd_valid
);

   logic                 rd_phase;
   logic [BIT_CNT_W-1:0] bit_cnt;
   logic [XLEN-1:0]      data_q;
   logic                 valid_q;

   assign rd_phase = i_ctl.en & ~i_ctl.init;

   // LSB arrives first and ends up at bit 0
   always_ff @(posedge i_clk) begin
      if (rd_phase)
         data_q <= {i_rd, data_q[XLEN-1:1]};
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         bit_cnt <= '0;
         valid_q <= 1'b0;
      end else begin
         if (rd_phase)
            bit_cnt <= bit_cnt + 1'b1;
         else
            bit_cnt <= '0;
         valid_q <= rd_phase && (bit_cnt == BIT_CNT_W'(XLEN - 1));   // One cycle after last bit
      end
   end

   assign o_rd_data  = data_q;
   assign o_rd_valid = valid_q;

   a_no_valid_in_init: assert property (@(posedge i_clk) disable iff (i_rst)
      $rose(o_rd_valid) |-> !i_ctl.init)
      else $error("result valid during init phase");

endmodule

`default_nettype wire

/* hw/lsu_mem_if.sv */
`timescale 1ns/1ns
`default_nettype none

module lsu_mem_if
   import lsu_pkg::*;
(
   input  logic            i_clk,
   input  logic            i_rst,
   input  mem_op_t         i_op,
   input  serial_ctl_t     i_ctl,
   input  logic            i_rs2,
   input  logic [XLEN-1:0] i_bus_rdt,
   input  logic            i_bus_ack,
   output bus_req_t        o_req,
   output logic            o_misalign,
   output logic            o_ack_evt,
   output logic            o_rd
);

   logic [NUM_LANES-1:0][LANE_W-1:0] lanes;
   logic [NUM_LANES-1:0]             lane_en;
   logic [NUM_LANES-1:0]             sel;
   logic [1:0]                       rd_lane;
   logic                             rd_phase;
   logic                             dat_valid;
   logic                             dat_cur;
   logic                             shift_in;
   logic                             signbit;
   logic                             misalign_cond;
   logic                             init_q;
   logic                             cyc_q;

   // Which rs2 byte a lane takes during init
   function automatic logic [1:0] src_byte(input mem_width_e w, input logic [1:0] lane);
      case (w)
         WORD:    return lane;
         HALF:    return {1'b0, lane[0]};
         default: return 2'b00;
      endcase
   endfunction

   assign o_ack_evt = cyc_q & i_bus_ack;
   assign rd_phase  = i_ctl.en & ~i_ctl.init;
   assign rd_lane   = i_op.lsb + i_ctl.bytecnt;
   assign dat_valid = (i_op.width == WORD) || (i_ctl.bytecnt == 2'd0) ||
                      ((i_op.width == HALF) && (i_ctl.bytecnt == 2'd1));
   assign dat_cur   = lanes[rd_lane][0];
   assign shift_in  = i_ctl.init ? i_rs2 : 1'b0;
   assign o_rd      = dat_valid ? dat_cur : (signbit & i_op.is_signed);

   assign misalign_cond = (i_op.lsb[0] && (i_op.width != BYTE)) ||
                          (i_op.lsb[1] && (i_op.width == WORD));

   always_comb begin
      case (i_op.width)
         WORD:    sel = 4'b1111;
         HALF:    sel = i_op.lsb[1] ? 4'b1100 : 4'b0011;
         default: sel = 4'b0001 << i_op.lsb;
      endcase
   end

   always_comb begin
      for (int k = 0; k < NUM_LANES; k++) begin
         if (i_ctl.init)
            lane_en[k] = i_ctl.en && (i_ctl.bytecnt == src_byte(i_op.width, 2'(k)));
         else
            lane_en[k] = rd_phase && dat_valid && (rd_lane == 2'(k));
      end
   end

   always_ff @(posedge i_clk) begin
      if (o_ack_evt) begin
         lanes <= i_bus_rdt;   // Load data lands in the lanes
      end else begin
         for (int k = 0; k < NUM_LANES; k++) begin
            if (lane_en[k])
               lanes[k] <= {shift_in, lanes[k][LANE_W-1:1]};
         end
      end
      if (rd_phase && dat_valid)
         signbit <= dat_cur;   // Last valid bit is the sign
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_misalign <= 1'b0;
         init_q     <= 1'b0;
         cyc_q      <= 1'b0;
      end else begin
         if (i_ctl.init)
            o_misalign <= misalign_cond;
         init_q <= i_ctl.init;
         if (o_ack_evt)
            cyc_q <= 1'b0;
         else if (init_q && !i_ctl.init && !o_misalign)
            cyc_q <= 1'b1;
      end
   end

   assign o_req = '{dat: lanes, sel: sel, we: i_op.is_store, cyc: cyc_q};

   a_sel_valid: assert property (@(posedge i_clk) disable iff (i_rst)
      cyc_q |-> (sel != '0) && !o_misalign)
      else $error("bus cycle with empty byte select or misaligned address");

   // Request frozen while the bus waits
   a_req_stable: assert property (@(posedge i_clk) disable iff (i_rst)
      (cyc_q && !i_bus_ack) |=> $stable(o_req))
      else $error("bus request changed before ack");

endmodule

`default_nettype wire

/* hw/lsu_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module lsu_decode
   import lsu_pkg::*;
(
   input  logic        i_clk,
   input  logic        i_rst,
   input  logic        i_start,
   input  logic [2:0]  i_funct3,
   input  logic        i_store,
   input  logic [1:0]  i_lsb,
   input  logic        i_misalign,
   input  logic        i_ack_evt,
   output mem_op_t     o_op,
   output serial_ctl_t o_ctl,
   output logic        o_busy,
   output logic        o_done
);

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_INIT,
      ST_CHECK,
      ST_BUS,
      ST_READ
   } state_e;

   state_e               state;
   logic [BIT_CNT_W-1:0] cnt;
   logic                 cnt_last;
   logic                 done_q;
   mem_op_t              op_q;

   function automatic mem_width_e width_of(input logic [2:0] f3);
      case (f3[1:0])
         2'b00:   return BYTE;
         2'b01:   return HALF;
         default: return WORD;
      endcase
   endfunction

   assign cnt_last = (cnt == BIT_CNT_W'(XLEN - 1));

   // Op is latched only when a start is accepted
   always_ff @(posedge i_clk) begin
      if (state == ST_IDLE && i_start) begin
         op_q.width     <= width_of(i_funct3);
         op_q.is_signed <= ~i_funct3[2];
         op_q.is_store  <= i_store;
         op_q.lsb       <= i_lsb;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         state  <= ST_IDLE;
         cnt    <= '0;
         done_q <= 1'b0;
      end else begin
         done_q <= 1'b0;
         case (state)
            ST_IDLE: begin
               cnt <= '0;
               if (i_start)
                  state <= ST_INIT;
            end
            ST_INIT: begin
               cnt <= cnt + 1'b1;   // Wraps to zero for the readout
               if (cnt_last)
                  state <= ST_CHECK;
            end
            ST_CHECK: begin
               if (i_misalign) begin
                  done_q <= 1'b1;   // No bus cycle
                  state  <= ST_IDLE;
               end else begin
                  state <= ST_BUS;
               end
            end
            ST_BUS: begin
               if (i_ack_evt) begin
                  if (op_q.is_store) begin
                     done_q <= 1'b1;
                     state  <= ST_IDLE;
                  end else begin
                     state <= ST_READ;
                  end
               end
            end
            ST_READ: begin
               cnt <= cnt + 1'b1;
               if (cnt_last) begin
                  done_q <= 1'b1;
                  state  <= ST_IDLE;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   assign o_op   = op_q;
   assign o_ctl  = '{en:      (state == ST_INIT) || (state == ST_READ),
                     init:    (state == ST_INIT),
                     bytecnt: cnt[BIT_CNT_W-1:BIT_CNT_W-2]};
   assign o_busy = (state != ST_IDLE);
   assign o_done = done_q;

   // Bus ack lands only between init and readout
   a_ack_in_bus: assert property (@(posedge i_clk) disable iff (i_rst)
      i_ack_evt |-> (state == ST_BUS))
      else $error("bus ack outside the bus phase");

endmodule

`default_nettype wire

/* hw/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

   localparam int XLEN      = 32;
   localparam int BIT_CNT_W = 5;   // Counts one serial word
   localparam int LANE_W    = 8;
   localparam int NUM_LANES = XLEN / LANE_W;

   // Access width from funct3[1:0]
   typedef enum logic [1:0] {
      BYTE = 2'd0,
      HALF = 2'd1,
      WORD = 2'd2
   } mem_width_e;

   // Decoded access held for the whole transfer
   typedef struct packed {
      mem_width_e width;
      logic       is_signed;
      logic       is_store;
      logic [1:0] lsb;
   } mem_op_t;

   // Serial phase control
   typedef struct packed {
      logic       en;       // Init or readout shifting
      logic       init;     // Store data shift-in phase
      logic [1:0] bytecnt;
   } serial_ctl_t;

   typedef struct packed {
      logic [XLEN-1:0]      dat;
      logic [NUM_LANES-1:0] sel;
      logic                 we;
      logic                 cyc;
   } bus_req_t;

endpackage

`default_nettype wire
